//--- files.f
+incdir+hdl
hdl/gcn_pkg.sv
hdl/gcn_ctrl.sv
hdl/gcn_adj_build.sv
hdl/gcn_aggregate.sv
hdl/gcn_transform_acc.sv
hdl/gcn_argmax.sv
hdl/gcn_top.sv
tb/gcn_tb.sv

//--- Bender.yml
package:
  name: gcn_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gcn_pkg.sv
      - hdl/gcn_ctrl.sv
      - hdl/gcn_adj_build.sv
      - hdl/gcn_aggregate.sv
      - hdl/gcn_transform_acc.sv
      - hdl/gcn_argmax.sv
      - hdl/gcn_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/gcn_tb.sv

//--- tb/gcn_tb.sv
`include "gcn_config.svh"

module gcn_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RUNS   = 24;
    localparam int RUN_LIMIT  = 200;
    // about 70 cycles per run plus reset and margin
    localparam int TIMEOUT_NS = (NUM_RUNS * 80 + 100) * 8;
    localparam int READS      = `GCN_FEATS / `GCN_LANES;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    gcn_pkg::coo_t          coo;
    gcn_pkg::feat_word_t    feat_data;
    gcn_pkg::wt_word_t      wt_data;
    logic                   rd_en;
    logic [`GCN_ADDR_W-1:0] rd_addr;
    gcn_pkg::result_t       y;
    logic                   done;

    // memory contents indexed [feature][node] and [feature][class]
    gcn_pkg::feat_t   feat_mem [`GCN_FEATS][`GCN_NODES];
    gcn_pkg::feat_t   wt_mem   [`GCN_FEATS][`GCN_CLASSES];
    logic [31:0]      rng;
    gcn_pkg::result_t exp_y;
    int               test_err;
    int               tests_pass;
    int               tests_fail;
    int               rd_cnt;
    int               rd_bursts;
    logic             done_prev;
    logic             rd_en_prev;

    gcn_top dut0 (
        .clk (clk), .rst_n (rst_n), .start (start), .coo (coo), .feat_data (feat_data),
        .wt_data (wt_data), .rd_en (rd_en), .rd_addr (rd_addr), .y (y), .done (done)
    );

    always #4 clk = ~clk;

    // asynchronous read where address a carries features a*LANES .. a*LANES+LANES-1
    always_comb begin
        for (int l = 0; l < `GCN_LANES; l++) begin
            for (int n = 0; n < `GCN_NODES; n++)
                feat_data[l][n] = feat_mem[int'(rd_addr) * `GCN_LANES + l][n];
            for (int c = 0; c < `GCN_CLASSES; c++)
                wt_data[l][c] = wt_mem[int'(rd_addr) * `GCN_LANES + l][c];
        end
    end

    //////////////////////////////////////////////////
    // random source and stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic gcn_pkg::edge_t make_edge(input int a, input int b);
        gcn_pkg::edge_t e;
        e.src = gcn_pkg::node_id_t'(a);
        e.dst = gcn_pkg::node_id_t'(b);
        return e;
    endfunction

    // ids 0..6 so some slots come out empty
    function automatic gcn_pkg::coo_t random_edges();
        gcn_pkg::coo_t c;
        for (int k = 0; k < `GCN_EDGES; k++)
            c[k] = make_edge(next_rand() % 7, next_rand() % 7);
        return c;
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic gcn_pkg::result_t expected_classes(input gcn_pkg::coo_t c);
        bit               a [`GCN_NODES][`GCN_NODES];
        longint           z [`GCN_NODES][`GCN_CLASSES];
        longint           h;
        longint           best;
        int               s;
        int               d;
        gcn_pkg::result_t r;
        foreach (a[i, j]) a[i][j] = 1'b0;
        foreach (z[i, k]) z[i][k] = 0;
        // symmetric OR of every edge with both ids set
        for (int k = 0; k < `GCN_EDGES; k++) begin
            s = int'(c[k].src);
            d = int'(c[k].dst);
            if (s != 0 && d != 0) begin
                a[s-1][d-1] = 1'b1;
                a[d-1][s-1] = 1'b1;
            end
        end
        // H = A*X per feature then Z += H*W
        for (int i = 0; i < `GCN_NODES; i++) begin
            for (int f = 0; f < `GCN_FEATS; f++) begin
                h = 0;
                for (int j = 0; j < `GCN_NODES; j++)
                    if (a[i][j]) h += feat_mem[f][j];
                for (int k = 0; k < `GCN_CLASSES; k++)
                    z[i][k] += h * wt_mem[f][k];
            end
        end
        // lowest index wins a tie
        for (int i = 0; i < `GCN_NODES; i++) begin
            r[i] = '0;
            best = z[i][0];
            for (int k = 1; k < `GCN_CLASSES; k++) begin
                if (z[i][k] > best) begin
                    best = z[i][k];
                    r[i] = gcn_pkg::class_t'(k);
                end
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(input string sig, input int expv, input int gotv);
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, sig, expv, gotv);
        test_err++;
    endtask

    // equal_wt gives every class the same weight per feature
    task automatic fill_memories(input bit equal_wt);
        gcn_pkg::feat_t w;
        for (int f = 0; f < `GCN_FEATS; f++) begin
            for (int n = 0; n < `GCN_NODES; n++)
                feat_mem[f][n] = gcn_pkg::feat_t'(next_rand());
            w = gcn_pkg::feat_t'(next_rand());
            for (int c = 0; c < `GCN_CLASSES; c++)
                wt_mem[f][c] = equal_wt ? w : gcn_pkg::feat_t'(next_rand());
        end
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("test %s: ok", name);
            tests_pass++;
        end else begin
            $display("test %s: %0d errors", name, test_err);
            tests_fail++;
        end
    endtask

    // one full run started on a falling edge with start low
    task automatic run_case(input string name, input gcn_pkg::coo_t edges);
        int waited;
        test_err  = 0;
        rd_cnt    = 0;
        rd_bursts = 0;
        waited    = 0;
        exp_y     = expected_classes(edges);
        coo       = edges;
        start     = 1'b1;
        while (!done && waited < RUN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("test %s: done did not rise within %0d cycles", name, RUN_LIMIT);
            test_err++;
        end
        // done must hold while start stays high
        repeat (4) begin
            @(negedge clk);
            assert (done) else report_mismatch("done", 1, done);
        end
        start = 1'b0;
        @(negedge clk);
        assert (!done) else report_mismatch("done", 0, done);
        assert (rd_cnt == READS) else report_mismatch("rd_en cycles", READS, rd_cnt);
        assert (rd_bursts == 1)
            else begin
                $display("test %s: read stream came in %0d bursts", name, rd_bursts);
                test_err++;
            end
        finish_test(name);
    endtask

    //////////////////////////////////////////////////
    // compare and stream monitors
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (done && !done_prev) begin
            for (int n = 0; n < `GCN_NODES; n++)
                assert (y[n] == exp_y[n])
                    else report_mismatch($sformatf("y[%0d]", n), exp_y[n], y[n]);
        end
        done_prev = done;
    end

    // addresses must run 0..READS-1 in one unbroken burst
    always @(negedge clk) begin
        if (rd_en) begin
            if (!rd_en_prev)
                rd_bursts++;
            assert (int'(rd_addr) == rd_cnt) else report_mismatch("rd_addr", rd_cnt, rd_addr);
            rd_cnt++;
        end
        rd_en_prev = rd_en;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run is stuck", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        gcn_pkg::coo_t hand;
        gcn_pkg::coo_t ties;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        coo        = '0;
        rng        = 32'h93eb;
        tests_pass = 0;
        tests_fail = 0;
        done_prev  = 1'b0;
        rd_en_prev = 1'b0;
        fill_memories(1'b0);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_err = 0;
        assert (!done) else report_mismatch("done", 0, done);
        assert (!rd_en) else report_mismatch("rd_en", 0, rd_en);
        assert (rd_addr == '0) else report_mismatch("rd_addr", 0, rd_addr);
        assert (y == '0) else report_mismatch("y", 0, y);
        finish_test("reset");

        // one edge given three times plus a self-loop and two zero-id slots
        hand = {make_edge(1, 2), make_edge(2, 1), make_edge(1, 2),
                make_edge(3, 3), make_edge(0, 5), make_edge(4, 0)};
        run_case("hand_built", hand);

        // nodes 2, 4 and 6 isolated and all classes weighted alike
        ties = {make_edge(1, 3), make_edge(3, 5), make_edge(5, 5),
                make_edge(0, 0), make_edge(0, 0), make_edge(0, 0)};
        fill_memories(1'b1);
        run_case("ties", ties);

        for (int t = 0; t < 20; t++) begin
            fill_memories(1'b0);
            run_case($sformatf("random_%0d", t), random_edges());
        end

        // back to back runs where scores of the previous run must not leak in
        run_case("restart_hand", hand);
        run_case("restart_empty", '0);

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/gcn_top.sv
`include "gcn_config.svh"

module gcn_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  gcn_pkg::coo_t          coo,
    input  gcn_pkg::feat_word_t    feat_data,
    input  gcn_pkg::wt_word_t      wt_data,
    output logic                   rd_en,
    output logic [`GCN_ADDR_W-1:0] rd_addr,
    output gcn_pkg::result_t       y,
    output logic                   done
);

    //////////////////////////////////////////////////
    // internal wiring
    //////////////////////////////////////////////////
    logic                run_start;
    logic                adj_done;
    logic                scan_start;
    logic                scan_done;
    logic                agg_valid;
    gcn_pkg::adj_mat_t   adj;
    gcn_pkg::agg_word_t  agg;
    gcn_pkg::wt_word_t   agg_wt;
    gcn_pkg::score_mat_t scores;

    // sequencing and shared read address
    gcn_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .adj_done   (adj_done),
        .scan_done  (scan_done),
        .run_start  (run_start),
        .rd_en      (rd_en),
        .scan_start (scan_start),
        .done       (done),
        .rd_addr    (rd_addr)
    );

    gcn_adj_build u_adj_build (
        .clk       (clk),
        .rst_n     (rst_n),
        .run_start (run_start),
        .coo       (coo),
        .adj       (adj),
        .adj_done  (adj_done)
    );

    // memories answer combinationally, sampled here while rd_en is high
    gcn_aggregate u_aggregate (
        .clk (clk), .rst_n (rst_n), .rd_en (rd_en), .feat_data (feat_data),
        .wt_data (wt_data), .adj (adj), .agg (agg), .agg_wt (agg_wt), .agg_valid (agg_valid)
    );

    gcn_transform_acc u_transform_acc (
        .clk (clk), .rst_n (rst_n), .run_start (run_start), .agg_valid (agg_valid),
        .agg (agg), .agg_wt (agg_wt), .scores (scores)
    );

    gcn_argmax u_argmax (
        .clk (clk), .rst_n (rst_n), .scan_start (scan_start), .scores (scores),
        .y (y), .scan_done (scan_done)
    );

endmodule

//--- hdl/gcn_argmax.sv
`include "gcn_config.svh"

module gcn_argmax (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scan_start,
    input  gcn_pkg::score_mat_t scores,
    output gcn_pkg::result_t    y,
    output logic                scan_done
);

    logic                                busy;
    gcn_pkg::class_t                     cls;
    logic                                last_cls;
    // running best score and its class per node
    gcn_pkg::score_t [`GCN_NODES-1:0]    best;
    gcn_pkg::score_t [`GCN_NODES-1:0]    best_nx;
    gcn_pkg::result_t                    idx;
    gcn_pkg::result_t                    idx_nx;

    assign last_cls = (cls == gcn_pkg::class_t'(`GCN_CLASSES - 1));

    // strictly greater only, so a tie keeps the lower class
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (scores[n][cls] > best[n]) begin
                best_nx[n] = scores[n][cls];
                idx_nx[n]  = cls;
            end else begin
                best_nx[n] = best[n];
                idx_nx[n]  = idx[n];
            end
        end
    end

    //////////////////////////////////////////////////
    // class walk, one class per cycle
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cls       <= '0;
            best      <= '0;
            idx       <= '0;
            y         <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (scan_start) begin
                // best starts at 0, an all-zero row ends on class 0
                busy <= 1'b1;
                cls  <= '0;
                best <= '0;
                idx  <= '0;
            end else if (busy) begin
                best <= best_nx;
                idx  <= idx_nx;
                cls  <= cls + 1'b1;
                if (last_cls) begin
                    busy      <= 1'b0;
                    y         <= idx_nx;
                    scan_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/gcn_transform_acc.sv
`include "gcn_config.svh"

module gcn_transform_acc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run_start,
    input  logic                agg_valid,
    input  gcn_pkg::agg_word_t  agg,
    input  gcn_pkg::wt_word_t   agg_wt,
    output gcn_pkg::score_mat_t scores
);

    gcn_pkg::score_mat_t score_nx;

    //////////////////////////////////////////////////
    // multiply and accumulate
    //////////////////////////////////////////////////

    // Z[i][c] += sum over lanes of H[lane][i] * W[lane][c]
    always_comb begin
        for (int i = 0; i < `GCN_NODES; i++) begin
            for (int c = 0; c < `GCN_CLASSES; c++) begin
                score_nx[i][c] = scores[i][c];
                for (int l = 0; l < `GCN_LANES; l++) begin
                    // widen both operands so the product is full width
                    score_nx[i][c] = score_nx[i][c]
                                   + gcn_pkg::score_t'(agg[l][i])
                                   * gcn_pkg::score_t'(agg_wt[l][c]);
                end
            end
        end
    end

    // scores clear at every run start, previous run has no effect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '0;
        end else if (run_start) begin
            scores <= '0;
        end else if (agg_valid) begin
            scores <= score_nx;
        end
    end

endmodule

//--- hdl/gcn_aggregate.sv
`include "gcn_config.svh"

module gcn_aggregate (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_en,
    input  gcn_pkg::feat_word_t feat_data,
    input  gcn_pkg::wt_word_t   wt_data,
    input  gcn_pkg::adj_mat_t   adj,
    output gcn_pkg::agg_word_t  agg,
    output gcn_pkg::wt_word_t   agg_wt,
    output logic                agg_valid
);

    // stage one holds the raw read
    gcn_pkg::feat_word_t feat_q;
    gcn_pkg::wt_word_t   wt_q;
    logic                vld_q;
    // neighbour sums for the word in stage one
    gcn_pkg::agg_word_t  sum_nx;

    //////////////////////////////////////////////////
    // stage one, sample the memories
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rd_en) begin
            feat_q <= feat_data;
            wt_q   <= wt_data;
        end
    end

    // A[i][j] masks feature of node j into the sum of node i
    always_comb begin
        for (int l = 0; l < `GCN_LANES; l++) begin
            for (int i = 0; i < `GCN_NODES; i++) begin
                sum_nx[l][i] = '0;
                for (int j = 0; j < `GCN_NODES; j++) begin
                    if (adj[i][j]) begin
                        sum_nx[l][i] = sum_nx[l][i] + gcn_pkg::agg_t'(feat_q[l][j]);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stage two, sums plus weights delayed to match
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (vld_q) begin
            agg    <= sum_nx;
            agg_wt <= wt_q;
        end
    end

    // valid follows the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q     <= 1'b0;
            agg_valid <= 1'b0;
        end else begin
            vld_q     <= rd_en;
            agg_valid <= vld_q;
        end
    end

endmodule

//--- hdl/gcn_adj_build.sv
`include "gcn_config.svh"

module gcn_adj_build (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run_start,
    input  gcn_pkg::coo_t     coo,
    output gcn_pkg::adj_mat_t adj,
    output logic              adj_done
);

    // captured edge list, only loaded at run start
    gcn_pkg::coo_t                   coo_q;
    gcn_pkg::edge_t                  cur;
    logic [$clog2(`GCN_EDGES)-1:0]   edge_idx;
    logic                            busy;
    logic                            last_edge;

    assign cur       = coo_q[edge_idx];
    assign last_edge = (edge_idx == ($clog2(`GCN_EDGES))'(`GCN_EDGES - 1));
    // high while the last edge is being merged
    assign adj_done  = busy && last_edge;

    always_ff @(posedge clk) begin
        if (run_start) begin
            coo_q <= coo;
        end
    end

    //////////////////////////////////////////////////
    // edge walk, one edge per cycle
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            edge_idx <= '0;
            adj      <= '0;
        end else if (run_start) begin
            busy     <= 1'b1;
            edge_idx <= '0;
            adj      <= '0;
        end else if (busy) begin
            // zero id means empty slot, skip it
            // duplicates just set the same bits again
            if (cur.src != '0 && cur.dst != '0) begin
                adj[cur.src - 1'b1][cur.dst - 1'b1] <= 1'b1;
                adj[cur.dst - 1'b1][cur.src - 1'b1] <= 1'b1;
            end
            edge_idx <= edge_idx + 1'b1;
            if (last_edge) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/gcn_ctrl.sv
`include "gcn_config.svh"

module gcn_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   adj_done,
    input  logic                   scan_done,
    output logic                   run_start,
    output logic                   rd_en,
    output logic                   scan_start,
    output logic                   done,
    output logic [`GCN_ADDR_W-1:0] rd_addr
);

    // one pass per start level: build, stream, drain, scan, then hold
    typedef enum logic [2:0] {
        S_IDLE,
        S_BUILD,
        S_STREAM,
        S_DRAIN,
        S_SCAN,
        S_HOLD
    } state_t;

    state_t state;
    state_t state_nx;
    // two drain cycles, one bit is enough
    logic   drain_cnt;
    logic   last_addr;

    // final read of the stream
    assign last_addr = (rd_addr == `GCN_ADDR_W'(`GCN_FEATS / `GCN_LANES - 1));

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE:   if (start) state_nx = S_BUILD;
            S_BUILD:  if (adj_done) state_nx = S_STREAM;
            S_STREAM: if (last_addr) state_nx = S_DRAIN;
            // lets the last two reads leave the aggregate pipe
            S_DRAIN:  if (drain_cnt) state_nx = S_SCAN;
            S_SCAN:   if (scan_done) state_nx = S_HOLD;
            // wait for start to drop before rearming
            S_HOLD:   if (!start) state_nx = S_IDLE;
            default:  state_nx = S_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // state, address and drain counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rd_addr   <= '0;
            drain_cnt <= 1'b0;
        end else begin
            state <= state_nx;
            // address steps once per streamed read, back to 0 after the last
            if (state == S_STREAM) begin
                rd_addr <= last_addr ? '0 : rd_addr + 1'b1;
            end
            if (state == S_DRAIN) begin
                drain_cnt <= ~drain_cnt;
            end else begin
                drain_cnt <= 1'b0;
            end
        end
    end

    // coo is captured on the same edge that leaves idle
    assign run_start  = (state == S_IDLE) && start;
    assign rd_en      = (state == S_STREAM);
    // final score update and scan init land on the same edge
    assign scan_start = (state == S_DRAIN) && drain_cnt;
    assign done       = (state == S_HOLD);

endmodule

//--- hdl/gcn_pkg.sv
`include "gcn_config.svh"

package gcn_pkg;

    //////////////////////////////////////////////////
    // graph input
    //////////////////////////////////////////////////

    // node ids start at 1, id 0 marks an unused edge slot
    typedef logic [2:0] node_id_t;

    typedef struct packed {
        node_id_t src;
        node_id_t dst;
    } edge_t;

    // edge list in coordinate form
    typedef edge_t [`GCN_EDGES-1:0] coo_t;

    // row i holds the neighbours of node i+1
    typedef logic [`GCN_NODES-1:0][`GCN_NODES-1:0] adj_mat_t;

    //////////////////////////////////////////////////
    // memory words
    //////////////////////////////////////////////////

    typedef logic [`GCN_BW-1:0] feat_t;

    // one feature read, indexed [lane][node]
    typedef feat_t [`GCN_LANES-1:0][`GCN_NODES-1:0] feat_word_t;
    // one weight read, indexed [lane][class]
    typedef feat_t [`GCN_LANES-1:0][`GCN_CLASSES-1:0] wt_word_t;

    //////////////////////////////////////////////////
    // datapath results
    //////////////////////////////////////////////////

    typedef logic [`GCN_AGG_W-1:0] agg_t;
    // aggregated features, indexed [lane][node]
    typedef agg_t [`GCN_LANES-1:0][`GCN_NODES-1:0] agg_word_t;

    typedef logic [`GCN_SCORE_W-1:0] score_t;
    // class scores, indexed [node][class]
    typedef score_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0] score_mat_t;

    typedef logic [1:0] class_t;
    typedef class_t [`GCN_NODES-1:0] result_t;

endpackage

//--- hdl/gcn_config.svh
`ifndef GCN_CONFIG_SVH
`define GCN_CONFIG_SVH

// graph size
`define GCN_NODES 6
`define GCN_EDGES 6

// feature memory has GCN_FEATS columns, read GCN_LANES at a time
`define GCN_FEATS 96
`define GCN_LANES 2
`define GCN_CLASSES 3

// raw feature / weight width
`define GCN_BW 5
// neighbour sum, holds GCN_NODES * (2**GCN_BW - 1)
`define GCN_AGG_W 8
// class score accumulator, sized so a full run never wraps
`define GCN_SCORE_W 21
// read address, covers GCN_FEATS / GCN_LANES reads
`define GCN_ADDR_W 6

`endif
